// ==== rtl/dmix_pkg.sv ====
package dmix_pkg;

    // Signed two's complement audio sample
    typedef logic signed [23:0] sample_t;

    // Unsigned gain with 7 fraction bits, 128 is unity
    typedef logic [7:0] gain_t;

    // Channel tag carried next to every sample
    typedef logic ch_t;

    localparam ch_t CH_LEFT  = 1'b0;
    localparam ch_t CH_RIGHT = 1'b1;

    // S/PDIF receiver states
    typedef enum logic [1:0] {
        RX_HUNT,
        RX_PREAMBLE,
        RX_DATA
    } rx_state_t;

    // Preamble pulse widths in unit intervals, first pulse in the top bits
    // B starts a block on the left channel
    localparam logic [7:0] PRE_B = {2'd3, 2'd1, 2'd1, 2'd3};

    // M is any other left subframe
    localparam logic [7:0] PRE_M = {2'd3, 2'd3, 2'd1, 2'd1};

    // W marks the right subframe
    localparam logic [7:0] PRE_W = {2'd3, 2'd2, 2'd1, 2'd2};

endpackage

// ==== rtl/spdif_rx.sv ====
`timescale 1ns/1ps

module spdif_rx
    import dmix_pkg::*;
#(
    parameter int UI_CLKS    = 4,
    parameter int LOCK_COUNT = 4
) (
    input  logic    clk245760,
    input  logic    rst,
    input  logic    signal_i,
    output sample_t data_o,
    output ch_t     ch_o,
    output logic    valid_o,
    output logic    locked_o
);

    // Decision points halfway between the nominal pulse lengths
    localparam int LIM_SHORT = UI_CLKS / 2;
    localparam int LIM_1_2   = (3 * UI_CLKS) / 2;
    localparam int LIM_2_3   = (5 * UI_CLKS) / 2;
    localparam int LIM_LONG  = (7 * UI_CLKS) / 2;
    localparam int CNT_W     = $clog2(LIM_LONG + 2);
    localparam int LOCK_W    = $clog2(LOCK_COUNT + 1);

    logic [2:0]        sync_q;
    logic              edge_seen;
    logic [CNT_W-1:0]  run_cnt;
    logic [1:0]        width;

    rx_state_t         state;
    logic [7:0]        pre_sr;
    logic [7:0]        pre_next;
    logic [1:0]        pre_cnt;
    logic              pre_match;
    ch_t               sub_ch;

    logic              half_one;
    logic [4:0]        bit_cnt;
    logic [27:0]       bit_sr;
    logic [27:0]       bit_next;
    logic              bit_val;
    logic              bit_done;

    logic              sub_err;
    logic              sub_good;
    logic [LOCK_W-1:0] good_cnt;

    // Two synchronizer flops plus one more for edge detection
    always_ff @(posedge clk245760) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], signal_i};
        end
    end

    assign edge_seen = sync_q[2] ^ sync_q[1];

    // Clocks since the last transition, saturating on an idle line
    always_ff @(posedge clk245760) begin
        if (rst) begin
            run_cnt <= '0;
        end else if (edge_seen) begin
            run_cnt <= CNT_W'(1);
        end else if (run_cnt != '1) begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    // Pulse width in UI, 0 flags a pulse outside all windows
    always_comb begin
        if (run_cnt <= CNT_W'(LIM_SHORT) || run_cnt > CNT_W'(LIM_LONG)) begin
            width = 2'd0;
        end else if (run_cnt <= CNT_W'(LIM_1_2)) begin
            width = 2'd1;
        end else if (run_cnt <= CNT_W'(LIM_2_3)) begin
            width = 2'd2;
        end else begin
            width = 2'd3;
        end
    end

    assign pre_next  = {pre_sr[5:0], width};
    assign pre_match = (pre_next == PRE_B) || (pre_next == PRE_M) || (pre_next == PRE_W);

    // Bit cell decode, a long pulse is 0 and two short ones are 1
    always_comb begin
        bit_val  = 1'b0;
        bit_done = 1'b0;
        if (width == 2'd2 && !half_one) begin
            bit_done = 1'b1;
        end else if (width == 2'd1 && half_one) begin
            bit_val  = 1'b1;
            bit_done = 1'b1;
        end
        bit_next = {bit_val, bit_sr[27:1]};
    end

    // Subframe outcome, evaluated on each transition
    always_comb begin
        sub_err  = 1'b0;
        sub_good = 1'b0;
        if (edge_seen) begin
            case (state)
                RX_PREAMBLE: begin
                    sub_err = (width == 2'd0) || (pre_cnt == 2'd3 && !pre_match);
                end
                RX_DATA: begin
                    if (bit_done && bit_cnt == 5'd27) begin
                        // Even parity over bits 4 to 31
                        sub_err  = ^bit_next;
                        sub_good = ~^bit_next;
                    end else if (!bit_done && !(width == 2'd1 && !half_one)) begin
                        sub_err = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            state    <= RX_HUNT;
            pre_cnt  <= '0;
            half_one <= 1'b0;
            bit_cnt  <= '0;
        end else if (edge_seen) begin
            case (state)
                RX_HUNT: begin
                    if (width == 2'd3) begin
                        pre_cnt <= 2'd1;
                        state   <= RX_PREAMBLE;
                    end
                end
                RX_PREAMBLE: begin
                    pre_cnt <= pre_cnt + 1'b1;
                    if (sub_err) begin
                        state <= RX_HUNT;
                    end else if (pre_cnt == 2'd3) begin
                        half_one <= 1'b0;
                        bit_cnt  <= '0;
                        state    <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (sub_err || sub_good) begin
                        state <= RX_HUNT;
                    end else if (bit_done) begin
                        half_one <= 1'b0;
                        bit_cnt  <= bit_cnt + 1'b1;
                    end else begin
                        half_one <= 1'b1;
                    end
                end
                default: state <= RX_HUNT;
            endcase
        end
    end

    // Shift registers and the captured sample
    always_ff @(posedge clk245760) begin
        if (edge_seen) begin
            if (state == RX_HUNT) begin
                pre_sr <= {6'd0, width};
            end else if (state == RX_PREAMBLE) begin
                pre_sr <= pre_next;
            end
            if (state == RX_PREAMBLE && pre_cnt == 2'd3) begin
                sub_ch <= (pre_next == PRE_W) ? CH_RIGHT : CH_LEFT;
            end
            if (state == RX_DATA && bit_done) begin
                bit_sr <= bit_next;
            end
        end
        if (sub_good) begin
            data_o <= sample_t'(bit_next[23:0]);
            ch_o   <= sub_ch;
        end
    end

    // Lock tracking, samples only pass once locked
    always_ff @(posedge clk245760) begin
        if (rst) begin
            good_cnt <= '0;
            locked_o <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= sub_good && locked_o;
            if (sub_err) begin
                good_cnt <= '0;
                locked_o <= 1'b0;
            end else if (sub_good && !locked_o) begin
                good_cnt <= good_cnt + 1'b1;
                if (good_cnt == LOCK_W'(LOCK_COUNT - 1)) begin
                    locked_o <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo
    import dmix_pkg::*;
#(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic    clk245760,
    input  logic    rst,
    input  logic    wr_i,
    input  sample_t wdata_i,
    input  ch_t     wch_i,
    output logic    full_o,
    output logic    rd_valid_o,
    output sample_t rdata_o,
    output ch_t     rch_o,
    input  logic    rd_ready_i
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    sample_t mem_data [DEPTH];
    ch_t     mem_ch   [DEPTH];

    // Pointers carry one extra bit to tell full from empty
    logic [DEPTH_LOG2:0] wr_ptr;
    logic [DEPTH_LOG2:0] rd_ptr;
    logic                do_write;
    logic                do_read;

    assign full_o = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                    (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);
    assign rd_valid_o = (wr_ptr != rd_ptr);

    // Writes into a full buffer are dropped
    assign do_write = wr_i && !full_o;
    assign do_read  = rd_valid_o && rd_ready_i;

    // Head entry is visible as long as valid is high
    assign rdata_o = mem_data[rd_ptr[DEPTH_LOG2-1:0]];
    assign rch_o   = mem_ch[rd_ptr[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk245760) begin
        if (do_write) begin
            mem_data[wr_ptr[DEPTH_LOG2-1:0]] <= wdata_i;
            mem_ch[wr_ptr[DEPTH_LOG2-1:0]]   <= wch_i;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/gain_stage.sv ====
`timescale 1ns/1ps

module gain_stage
    import dmix_pkg::*;
(
    input  logic    clk245760,
    input  logic    rst,
    input  logic    in_valid_i,
    output logic    in_ready_o,
    input  sample_t in_data_i,
    input  ch_t     in_ch_i,
    input  gain_t   gain_l_i,
    input  gain_t   gain_r_i,
    output logic    out_valid_o,
    input  logic    out_ready_i,
    output sample_t out_data_o,
    output ch_t     out_ch_o
);

    // Sample times gain with a sign bit in front of the gain
    localparam int PROD_W = $bits(sample_t) + $bits(gain_t) + 1;
    localparam logic signed [PROD_W-1:0] SAT_MAX = PROD_W'(32'sd8388607);
    localparam logic signed [PROD_W-1:0] SAT_MIN = PROD_W'(-32'sd8388608);

    logic                     advance;
    gain_t                    gain_sel;
    logic                     s1_valid;
    logic signed [PROD_W-1:0] s1_prod;
    ch_t                      s1_ch;
    logic signed [PROD_W-1:0] scaled;
    sample_t                  clamped;

    // Whole pipe moves when the output slot frees up
    assign advance    = !out_valid_o || out_ready_i;
    assign in_ready_o = advance;

    assign gain_sel = (in_ch_i == CH_RIGHT) ? gain_r_i : gain_l_i;

    // Floor division by 128, then clamp into sample range
    always_comb begin
        scaled = s1_prod >>> 7;
        if (scaled > SAT_MAX) begin
            clamped = {1'b0, {23{1'b1}}};
        end else if (scaled < SAT_MIN) begin
            clamped = {1'b1, 23'd0};
        end else begin
            clamped = sample_t'(scaled[23:0]);
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            out_valid_o <= 1'b0;
        end else if (advance) begin
            s1_valid    <= in_valid_i;
            out_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk245760) begin
        if (advance) begin
            s1_prod    <= in_data_i * $signed({1'b0, gain_sel});
            s1_ch      <= in_ch_i;
            out_data_o <= clamped;
            out_ch_o   <= s1_ch;
        end
    end

endmodule

// ==== rtl/i2s_tx.sv ====
`timescale 1ns/1ps

module i2s_tx
    import dmix_pkg::*;
#(
    parameter int BCK_CLKS = 8
) (
    input  logic    clk245760,
    input  logic    rst,
    input  logic    in_valid_i,
    output logic    in_ready_o,
    input  sample_t in_data_i,
    input  ch_t     in_ch_i,
    output logic    bck_o,
    output logic    lrck_o,
    output logic    data_o,
    output logic    underrun_o
);

    localparam int DIV_W = $clog2(BCK_CLKS);

    // Divider phases for the bit clock edges and the slot load
    localparam logic [DIV_W-1:0] DIV_RISE = DIV_W'(BCK_CLKS / 2 - 1);
    localparam logic [DIV_W-1:0] DIV_FALL = DIV_W'(BCK_CLKS - 1);
    localparam logic [DIV_W-1:0] DIV_LOAD = DIV_W'(BCK_CLKS - 2);

    logic [DIV_W-1:0] div_cnt;
    logic [5:0]       bit_cnt;
    logic             fall_now;
    logic             slot_end;
    logic             load_slot;
    ch_t              next_ch;
    sample_t          shift_q;

    assign fall_now = (div_cnt == DIV_FALL);
    assign slot_end = (bit_cnt[4:0] == 5'd31);

    // Fetch for the coming slot one clock before the word clock moves
    assign load_slot  = (div_cnt == DIV_LOAD) && slot_end;
    assign in_ready_o = load_slot;
    assign next_ch    = ~bit_cnt[5];

    // Upper bit of the frame counter is the word clock
    assign lrck_o = bit_cnt[5];

    always_ff @(posedge clk245760) begin
        if (rst) begin
            div_cnt    <= '0;
            bit_cnt    <= '0;
            bck_o      <= 1'b0;
            data_o     <= 1'b0;
            shift_q    <= '0;
            underrun_o <= 1'b0;
        end else begin
            underrun_o <= load_slot && !in_valid_i;

            if (fall_now) begin
                div_cnt <= '0;
                bck_o   <= 1'b0;
                bit_cnt <= bit_cnt + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                if (div_cnt == DIV_RISE) begin
                    bck_o <= 1'b1;
                end
            end

            if (load_slot) begin
                // Wrong tag or nothing ready sends a silent slot
                if (in_valid_i && in_ch_i == next_ch) begin
                    shift_q <= in_data_i;
                end else begin
                    shift_q <= '0;
                end
            end else if (fall_now && !slot_end) begin
                shift_q <= shift_q << 1;
            end

            // MSB goes out one bit clock after the word clock edge
            if (fall_now) begin
                data_o <= slot_end ? 1'b0 : shift_q[23];
            end
        end
    end

endmodule

// ==== rtl/dmix_top.sv ====
`timescale 1ns/1ps

module dmix_top
    import dmix_pkg::*;
#(
    parameter int UI_CLKS    = 4,
    parameter int LOCK_COUNT = 4,
    parameter int DEPTH_LOG2 = 4,
    parameter int BCK_CLKS   = 8
) (
    input  logic  clk245760,
    input  logic  rst,
    input  logic  spdif_i,
    input  gain_t gain_l_i,
    input  gain_t gain_r_i,
    output logic  dac_bck_o,
    output logic  dac_lrck_o,
    output logic  dac_data_o,
    output logic  locked_o,
    output logic  underrun_o
);

    logic    rx_valid;
    sample_t rx_data;
    ch_t     rx_ch;

    logic    f_valid;
    logic    f_ready;
    sample_t f_data;
    ch_t     f_ch;

    logic    g_valid;
    logic    g_ready;
    sample_t g_data;
    ch_t     g_ch;

    spdif_rx #(
        .UI_CLKS    (UI_CLKS),
        .LOCK_COUNT (LOCK_COUNT)
    ) rx0 (
        .clk245760 (clk245760),
        .rst       (rst),
        .signal_i  (spdif_i),
        .data_o    (rx_data),
        .ch_o      (rx_ch),
        .valid_o   (rx_valid),
        .locked_o  (locked_o)
    );

    // Receiver cannot stall, overflow drops samples
    sample_fifo #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) fifo0 (
        .clk245760  (clk245760),
        .rst        (rst),
        .wr_i       (rx_valid),
        .wdata_i    (rx_data),
        .wch_i      (rx_ch),
        .full_o     (),
        .rd_valid_o (f_valid),
        .rdata_o    (f_data),
        .rch_o      (f_ch),
        .rd_ready_i (f_ready)
    );

    gain_stage gain0 (
        .clk245760   (clk245760),
        .rst         (rst),
        .in_valid_i  (f_valid),
        .in_ready_o  (f_ready),
        .in_data_i   (f_data),
        .in_ch_i     (f_ch),
        .gain_l_i    (gain_l_i),
        .gain_r_i    (gain_r_i),
        .out_valid_o (g_valid),
        .out_ready_i (g_ready),
        .out_data_o  (g_data),
        .out_ch_o    (g_ch)
    );

    i2s_tx #(
        .BCK_CLKS (BCK_CLKS)
    ) tx0 (
        .clk245760  (clk245760),
        .rst        (rst),
        .in_valid_i (g_valid),
        .in_ready_o (g_ready),
        .in_data_i  (g_data),
        .in_ch_i    (g_ch),
        .bck_o      (dac_bck_o),
        .lrck_o     (dac_lrck_o),
        .data_o     (dac_data_o),
        .underrun_o (underrun_o)
    );

endmodule

// ==== tests/tb_dmix.sv ====
`timescale 1ns/1ps

module tb_dmix
    import dmix_pkg::*;
();

    localparam int UI_CLKS = 4;

    logic  clk245760;
    logic  rst;
    logic  spdif_i;
    gain_t gain_l_i;
    gain_t gain_r_i;
    logic  dac_bck_o;
    logic  dac_lrck_o;
    logic  dac_data_o;
    logic  locked_o;
    logic  underrun_o;

    integer seed;
    int     errors;
    int     checks;

    // Samples in the order the DAC should play them
    sample_t exp_q[$];
    ch_t     exp_ch_q[$];

    // Captured slots, sample in the top 24 bits, word clock level as tag
    logic [31:0] cap_q[$];
    logic        cap_tag_q[$];

    logic [30:0] slot_sr;
    int          slot_bits;
    logic        prev_lrck = 1'b0;
    logic        framed = 1'b0;
    logic [31:0] slot_word;

    dmix_top #(
        .UI_CLKS (UI_CLKS)
    ) dut0 (
        .clk245760  (clk245760),
        .rst        (rst),
        .spdif_i    (spdif_i),
        .gain_l_i   (gain_l_i),
        .gain_r_i   (gain_r_i),
        .dac_bck_o  (dac_bck_o),
        .dac_lrck_o (dac_lrck_o),
        .dac_data_o (dac_data_o),
        .locked_o   (locked_o),
        .underrun_o (underrun_o)
    );

    always #4 clk245760 = ~clk245760;

    // I2S capture, a slot runs from one bit after the word clock edge to the next edge
    always @(posedge dac_bck_o) begin
        if (framed && dac_lrck_o != prev_lrck) begin
            slot_word = {slot_sr, dac_data_o};
            checks++;
            assert (slot_bits == 31) else begin
                errors++;
                $display("MISMATCH at %0t: word clock toggled after %0d bit clocks, expected 32",
                         $time, slot_bits + 1);
            end
            checks++;
            assert (slot_word[7:0] == 8'h00) else begin
                errors++;
                $display("MISMATCH at %0t: slot tail bits are %h, expected 00",
                         $time, slot_word[7:0]);
            end
            cap_q.push_back(slot_word);
            cap_tag_q.push_back(prev_lrck);
            slot_bits = 0;
        end else if (framed) begin
            slot_sr = {slot_sr[29:0], dac_data_o};
            slot_bits++;
        end else if (dac_lrck_o != prev_lrck) begin
            framed    = 1'b1;
            slot_bits = 0;
        end
        prev_lrck = dac_lrck_o;
    end

    // Gain model, floor of product over 128 then clamp
    function automatic sample_t scaled_sample(input sample_t s, input gain_t g);
        longint prod;
        longint q;
        prod = longint'(s) * longint'(g);
        q = prod / 128;
        if (prod < 0 && (prod % 128) != 0) begin
            q = q - 1;
        end
        if (q > 64'sd8388607) begin
            q = 64'sd8388607;
        end else if (q < -64'sd8388608) begin
            q = -64'sd8388608;
        end
        return sample_t'(q);
    endfunction

    task automatic check_flag(input logic got, input logic want, input string what);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_sample(input sample_t got, input logic got_tag, input sample_t want,
                                input ch_t want_ch);
        checks++;
        assert (got == want && got_tag == want_ch) else begin
            errors++;
            $display("MISMATCH at %0t: got %h in slot %0d, expected %h in slot %0d",
                     $time, got, got_tag, want, want_ch);
        end
    endtask

    task automatic expect_sample(input ch_t ch, input sample_t s);
        exp_q.push_back(scaled_sample(s, (ch == CH_RIGHT) ? gain_r_i : gain_l_i));
        exp_ch_q.push_back(ch);
    endtask

    task automatic random_sample(output sample_t s);
        s = sample_t'($random(seed));
        // Tiny positive levels would scale down to a silent slot
        if (s[23:8] == '0) begin
            s[16] = 1'b1;
        end
    endtask

    // One transition, then the line holds for the given number of UI
    task automatic line_pulse(input int ui);
        spdif_i = ~spdif_i;
        repeat (ui * UI_CLKS) @(posedge clk245760);
        #1;
    endtask

    task automatic send_subframe(input logic [7:0] pre, input sample_t s, input bit bad_parity);
        logic [27:0] cells;
        // Sample LSB first, then V, U and C at zero, parity last
        cells = {4'b0000, s};
        cells[27] = ^cells[26:0] ^ bad_parity;
        for (int i = 3; i >= 0; i--) begin
            line_pulse(int'(pre[2*i +: 2]));
        end
        for (int i = 0; i < 28; i++) begin
            if (cells[i]) begin
                line_pulse(1);
                line_pulse(1);
            end else begin
                line_pulse(2);
            end
        end
    endtask

    task automatic send_pair(input logic [7:0] pre, input sample_t left, input sample_t right,
                             input bit played);
        send_subframe(pre, left, 1'b0);
        send_subframe(PRE_W, right, 1'b0);
        if (played) begin
            expect_sample(CH_LEFT, left);
            expect_sample(CH_RIGHT, right);
        end
    endtask

    task automatic send_random_pairs(input int n, input bit played, input bit block_start);
        sample_t left;
        sample_t right;
        for (int i = 0; i < n; i++) begin
            random_sample(left);
            random_sample(right);
            send_pair((block_start && i == 0) ? PRE_B : PRE_M, left, right, played);
        end
    endtask

    // Closing transition ends the last bit cell of the burst
    task automatic end_burst();
        spdif_i = ~spdif_i;
        repeat (4 * UI_CLKS) @(posedge clk245760);
        #1;
    endtask

    // Start a burst so left samples reach the DAC side during the right slot
    task automatic align_to_frame();
        int   n;
        logic last;
        logic found;
        n = 0;
        found = 1'b0;
        last = dac_lrck_o;
        while (!found && n < 2000) begin
            @(posedge clk245760);
            #1;
            found = last && !dac_lrck_o;
            last = dac_lrck_o;
            n++;
        end
        if (!found) begin
            errors++;
            $display("Timeout: the word clock never returned to the left slot");
        end
        repeat (120) @(posedge clk245760);
        #1;
    endtask

    task automatic next_word(output logic [31:0] w, output logic tag, output bit ok);
        int n;
        n = 0;
        while (cap_q.size() == 0 && n < 1000) begin
            @(posedge clk245760);
            #1;
            n++;
        end
        ok = (cap_q.size() != 0);
        if (ok) begin
            w = cap_q.pop_front();
            tag = cap_tag_q.pop_front();
        end
    endtask

    // Silent slots between samples are skipped, order must hold
    task automatic check_outputs(input string label);
        logic [31:0] w;
        logic        tag;
        bit          ok;
        int          gaps;
        sample_t     want;
        ch_t         want_ch;
        gaps = 0;
        while (exp_q.size() != 0) begin
            next_word(w, tag, ok);
            if (!ok || gaps > 64) begin
                errors++;
                $display("%s: %0d expected samples never reached the DAC", label, exp_q.size());
                exp_q.delete();
                exp_ch_q.delete();
            end else if (w[31:8] == '0) begin
                gaps++;
            end else begin
                want = exp_q.pop_front();
                want_ch = exp_ch_q.pop_front();
                check_sample(sample_t'(w[31:8]), tag, want, want_ch);
                gaps = 0;
            end
        end
    endtask

    task automatic wait_underrun();
        int n;
        n = 0;
        while (underrun_o !== 1'b1 && n < 1000) begin
            @(posedge clk245760);
            #1;
            n++;
        end
        if (underrun_o !== 1'b1) begin
            errors++;
            $display("underrun_o never pulsed after the burst was played");
        end else begin
            @(posedge clk245760);
            #1;
            check_flag(underrun_o, 1'b0, "underrun_o one cycle after its pulse");
        end
    endtask

    task automatic check_silence(input int n);
        logic [31:0] w;
        logic        tag;
        bit          ok;
        for (int i = 0; i < n; i++) begin
            next_word(w, tag, ok);
            if (!ok) begin
                errors++;
                $display("No I2S slot was captured while the input was idle");
            end else begin
                checks++;
                assert (w == '0) else begin
                    errors++;
                    $display("MISMATCH at %0t: idle slot holds %h, expected zero", $time, w);
                end
            end
        end
    endtask

    task automatic check_leftovers();
        int extra;
        extra = 0;
        foreach (cap_q[i]) begin
            if (cap_q[i][31:8] != '0) begin
                extra++;
            end
        end
        checks++;
        assert (extra == 0) else begin
            errors++;
            $display("MISMATCH at %0t: %0d samples reached the DAC that were never sent",
                     $time, extra);
        end
        if (!framed) begin
            errors++;
            $display("No I2S frame was captured");
        end
    endtask

    task automatic test_passthrough();
        check_flag(locked_o, 1'b0, "locked_o before any input");
        align_to_frame();
        // First four subframes only build up lock
        send_random_pairs(2, 1'b0, 1'b1);
        send_random_pairs(8, 1'b1, 1'b0);
        end_burst();
        check_flag(locked_o, 1'b1, "locked_o after 20 good subframes");
        check_outputs("Pass-through");
    endtask

    task automatic test_gain();
        gain_l_i = 8'd64;
        gain_r_i = 8'd255;
        align_to_frame();
        send_pair(PRE_B, 24'h7fffff, 24'h7fffff, 1'b1);
        send_pair(PRE_M, 24'h800000, 24'h800000, 1'b1);
        send_pair(PRE_M, -24'sd301, -24'sd301, 1'b1);
        send_random_pairs(5, 1'b1, 1'b0);
        end_burst();
        check_outputs("Gain");
    endtask

    task automatic test_parity_error();
        sample_t s;
        gain_l_i = 8'd128;
        gain_r_i = 8'd128;
        check_flag(locked_o, 1'b1, "locked_o before the parity error");
        align_to_frame();
        random_sample(s);
        send_subframe(PRE_M, s, 1'b0);
        expect_sample(CH_LEFT, s);
        random_sample(s);
        send_subframe(PRE_W, s, 1'b1);
        random_sample(s);
        send_subframe(PRE_M, s, 1'b0);
        check_flag(locked_o, 1'b0, "locked_o after a parity error");
        random_sample(s);
        send_subframe(PRE_W, s, 1'b0);
        // Two more good subframes complete the relock, then samples flow again
        send_random_pairs(1, 1'b0, 1'b0);
        send_random_pairs(6, 1'b1, 1'b0);
        end_burst();
        check_flag(locked_o, 1'b1, "locked_o after relock");
        check_outputs("Parity error");
    endtask

    task automatic test_underrun();
        align_to_frame();
        send_random_pairs(3, 1'b1, 1'b1);
        end_burst();
        check_outputs("Underrun");
        wait_underrun();
        check_silence(4);
    endtask

    initial begin
        seed      = 32'hce72_2bc3;
        errors    = 0;
        checks    = 0;
        clk245760 = 1'b0;
        rst       = 1'b1;
        spdif_i   = 1'b0;
        gain_l_i  = 8'd128;
        gain_r_i  = 8'd128;
        repeat (2) @(posedge clk245760);
        #1;
        check_flag(locked_o, 1'b0, "locked_o in reset");
        check_flag(underrun_o, 1'b0, "underrun_o in reset");
        check_flag(dac_bck_o, 1'b0, "dac_bck_o in reset");
        check_flag(dac_lrck_o, 1'b0, "dac_lrck_o in reset");
        check_flag(dac_data_o, 1'b0, "dac_data_o in reset");
        rst = 1'b0;

        test_passthrough();
        test_gain();
        test_parity_error();
        test_underrun();
        check_leftovers();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/dmix_pkg.sv
rtl/spdif_rx.sv
rtl/sample_fifo.sv
rtl/gain_stage.sv
rtl/i2s_tx.sv
rtl/dmix_top.sv
tests/tb_dmix.sv
